// ==== hdl/cpuParams.svh ====
// Width and depth macros for the multi-cycle core
`ifndef CPU_PARAMS_SVH
`define CPU_PARAMS_SVH

// Data path
`define CPU_XLEN 32
`define CPU_REG_AW 5

// Word addresses, 256 words each
`define CPU_IMEM_AW 8
`define CPU_DMEM_AW 8

// Instruction fields
`define CPU_IMM_W 14
`define CPU_JIMM_W 24
`define CPU_SHAMT_W 5

// Encoded instruction word
`define CPU_INSTR_W 32
`define CPU_OPCODE_W 5
`define CPU_TYPE_W 2

`endif

// ==== hdl/cpuPkg.sv ====
// Package with instruction enums and the decoded, result, program-write and trace structs
`default_nettype none
`include "cpuParams.svh"

package cpuPkg;

  typedef logic [`CPU_XLEN-1:0] word_t;
  typedef logic [`CPU_INSTR_W-1:0] instr_t;

  typedef enum logic [`CPU_TYPE_W-1:0] {
    TypeR = 2'd0,
    TypeJ = 2'd1,
    TypeI = 2'd2,
    TypeS = 2'd3
  } instrType_e;

  // Meaning depends on the type field
  typedef enum logic [`CPU_OPCODE_W-1:0] {
    OpAnd = 5'd0, // AND, ANDI, SLL, J
    OpAdd = 5'd1, // ADD, ADDI, SRL
    OpSub = 5'd2, // SUB, LW, SLLV
    OpCmp = 5'd3, // CMP, SW, SRLV
    OpBeq = 5'd4  // BEQ only
  } opcode_e;

  typedef struct packed {
    instrType_e instrType;
    opcode_e opcode;
    logic [`CPU_REG_AW-1:0] rs1;
    logic [`CPU_REG_AW-1:0] rs2; // Index for read port B
    logic [`CPU_REG_AW-1:0] rd;
    word_t imm;                  // Already extended
    logic [`CPU_SHAMT_W-1:0] shamt;
    logic [`CPU_JIMM_W-1:0] jumpOffset;
    logic regWrite;
    logic memRead;
    logic memWrite;
    logic branch;
    logic jump;
    logic stop;
    logic valid;
  } decodedInstr_t;

  typedef struct packed {
    word_t aluResult;
    logic [`CPU_IMEM_AW-1:0] nextPc;
    logic taken;
    logic [`CPU_DMEM_AW-1:0] dataAddr;
  } execResult_t;

  typedef struct packed {
    logic strobe;
    logic [`CPU_IMEM_AW-1:0] addr;
    instr_t instr;
  } progWrite_t;

  typedef struct packed {
    logic [`CPU_IMEM_AW-1:0] pc;
    logic regWrite;
    logic [`CPU_REG_AW-1:0] rd;
    word_t writeData;
    logic memWrite;
    logic [`CPU_DMEM_AW-1:0] memAddr;
    word_t storeData;
  } retireTrace_t;

endpackage

`default_nettype wire

// ==== hdl/syncRam.sv ====
// Simple dual-port RAM with registered read and a typed payload
`default_nettype none

module syncRam #(
  parameter type payload_t = logic [31:0],
  parameter int addrWidth = 8
) (
  input  logic                 clk,
  input  logic                 writeEnable,
  input  logic [addrWidth-1:0] writeAddr,
  input  payload_t             writeData,
  input  logic                 readEnable,
  input  logic [addrWidth-1:0] readAddr,
  output payload_t             readData
);

  payload_t mem [2**addrWidth];

  always_ff @(posedge clk) begin
    if (writeEnable) begin
      mem[writeAddr] <= writeData;
    end
    // Output holds while the read enable is low
    if (readEnable) begin
      readData <= mem[readAddr];
    end
  end

  writeAddrKnown: assert property (@(posedge clk)
    writeEnable |-> !$isunknown(writeAddr))
    else $error("syncRam write address has unknown bits");

  readAddrKnown: assert property (@(posedge clk)
    readEnable |-> !$isunknown(readAddr))
    else $error("syncRam read address has unknown bits");

endmodule

`default_nettype wire

// ==== hdl/registerFile.sv ====
// Register file with two combinational reads, one write and register 0 fixed at zero
`default_nettype none
`include "cpuParams.svh"

module registerFile import cpuPkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  logic [`CPU_REG_AW-1:0] readAddrA,
  input  logic [`CPU_REG_AW-1:0] readAddrB,
  input  logic                   writeEnable,
  input  logic [`CPU_REG_AW-1:0] writeAddr,
  input  word_t                  writeData,
  output word_t                  readDataA,
  output word_t                  readDataB
);

  word_t regs [2**`CPU_REG_AW];

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < 2**`CPU_REG_AW; i++) begin
        regs[i] <= '0;
      end
    end else if (writeEnable && writeAddr != '0) begin // r0 never written
      regs[writeAddr] <= writeData;
    end
  end

  assign readDataA = regs[readAddrA];
  assign readDataB = regs[readAddrB];

  // Write index must be clean whenever the sequencer commits
  writeAddrKnown: assert property (@(posedge clk) disable iff (reset)
    writeEnable |-> !$isunknown(writeAddr))
    else $error("registerFile write index has unknown bits");

endmodule

`default_nettype wire

// ==== hdl/instructionDecode.sv ====
// Instruction decoder with field extraction, immediate extension and control flags
`default_nettype none
`include "cpuParams.svh"

module instructionDecode import cpuPkg::*; (
  input  instr_t        instruction,
  output decodedInstr_t decoded
);

  logic [`CPU_IMM_W-1:0] immRaw;

  assign immRaw = instruction[28:15];

  always_comb begin
    decoded = '0;
    decoded.instrType  = instrType_e'(instruction[30:29]);
    decoded.opcode     = opcode_e'(instruction[4:0]);
    decoded.rs1        = instruction[9:5];
    decoded.rd         = instruction[14:10];
    decoded.rs2        = instruction[19:15];
    decoded.shamt      = instruction[24:20];
    decoded.jumpOffset = instruction[28:5];
    decoded.stop       = instruction[31]; // Kept even for undefined opcodes
    decoded.imm        = {{(`CPU_XLEN-`CPU_IMM_W){immRaw[`CPU_IMM_W-1]}}, immRaw};

    case (decoded.instrType)
      TypeR: begin
        decoded.valid    = decoded.opcode <= OpCmp;
        decoded.regWrite = decoded.valid;
      end
      TypeJ: begin
        decoded.valid = decoded.opcode == OpAnd;
        decoded.jump  = decoded.valid;
      end
      TypeI: begin
        // Port B carries rd for SW data and the BEQ compare
        decoded.rs2      = decoded.rd;
        decoded.valid    = decoded.opcode <= OpBeq;
        decoded.regWrite = decoded.opcode <= OpSub; // ANDI, ADDI, LW
        decoded.memRead  = decoded.opcode == OpSub;
        decoded.memWrite = decoded.opcode == OpCmp;
        decoded.branch   = decoded.opcode == OpBeq;
        if (decoded.opcode == OpAnd) begin
          decoded.imm = {{(`CPU_XLEN-`CPU_IMM_W){1'b0}}, immRaw}; // ANDI zero-extends
        end
      end
      default: begin // S-type shifts
        decoded.valid    = decoded.opcode <= OpCmp;
        decoded.regWrite = decoded.valid;
      end
    endcase
  end

endmodule

`default_nettype wire

// ==== hdl/executeUnit.sv ====
// Combined ALU with branch resolution, next PC and data address
`default_nettype none
`include "cpuParams.svh"

module executeUnit import cpuPkg::*; (
  input  decodedInstr_t            decoded,
  input  logic [`CPU_IMEM_AW-1:0]  pc,
  input  word_t                    operandA,
  input  word_t                    operandB,
  output execResult_t              result
);

  word_t immSum;
  logic [`CPU_IMEM_AW-1:0] pcNext;

  assign immSum = operandA + decoded.imm;
  assign pcNext = pc + `CPU_IMEM_AW'(1);

  always_comb begin
    result = '0;
    result.dataAddr = immSum[`CPU_DMEM_AW-1:0]; // Wraps to data memory size
    result.taken    = decoded.jump || (decoded.branch && operandA == operandB);

    case (decoded.instrType)
      TypeR: begin
        case (decoded.opcode)
          OpAnd:   result.aluResult = operandA & operandB;
          OpAdd:   result.aluResult = operandA + operandB;
          OpSub:   result.aluResult = operandA - operandB;
          OpCmp:   result.aluResult = {{(`CPU_XLEN-1){1'b0}}, operandA < operandB};
          default: result.aluResult = '0;
        endcase
      end
      TypeI: begin
        case (decoded.opcode)
          OpAnd:   result.aluResult = operandA & decoded.imm;
          OpAdd,
          OpSub,
          OpCmp:   result.aluResult = immSum; // ADDI, LW, SW
          default: result.aluResult = '0;
        endcase
      end
      TypeS: begin
        case (decoded.opcode)
          OpAnd:   result.aluResult = operandA << decoded.shamt;
          OpAdd:   result.aluResult = operandA >> decoded.shamt;
          OpSub:   result.aluResult = operandA << operandB[`CPU_SHAMT_W-1:0];
          OpCmp:   result.aluResult = operandA >> operandB[`CPU_SHAMT_W-1:0];
          default: result.aluResult = '0;
        endcase
      end
      default: result.aluResult = '0; // J writes nothing
    endcase

    // Offset relative to the following word, modulo memory size
    if (decoded.jump) begin
      result.nextPc = pcNext + decoded.jumpOffset[`CPU_IMEM_AW-1:0];
    end else if (result.taken) begin
      result.nextPc = pcNext + decoded.imm[`CPU_IMEM_AW-1:0]; // BEQ offset is the immediate
    end else begin
      result.nextPc = pcNext;
    end
  end

endmodule

`default_nettype wire

// ==== hdl/controlSequencer.sv ====
// Sequencer FSM with PC, memory strobes, write-back, retire trace and halt
`default_nettype none
`include "cpuParams.svh"

module controlSequencer import cpuPkg::*; (
  input  logic                   clk,
  input  logic                   reset,
  input  logic                   run,
  input  decodedInstr_t          decoded,
  input  execResult_t            result,
  input  word_t                  storeData,
  input  word_t                  loadData,
  output logic                   fetchEnable,
  output logic [`CPU_IMEM_AW-1:0] pc,
  output logic                   dataRead,
  output logic                   dataWrite,
  output logic [`CPU_DMEM_AW-1:0] dataAddr,
  output word_t                  dataWriteValue,
  output logic                   regWriteEnable,
  output logic [`CPU_REG_AW-1:0] regWriteAddr,
  output word_t                  regWriteData,
  output logic                   retire,
  output retireTrace_t           trace,
  output logic                   halted
);

  typedef enum logic [2:0] {Idle, Fetch, Execute, LoadWait, Halted} state_e;

  state_e state, nextState;
  logic inExecute;

  assign inExecute   = state == Execute;
  assign fetchEnable = state == Fetch;
  assign halted      = state == Halted;
  assign retire      = (inExecute && !decoded.memRead) || state == LoadWait;

  // Data memory, LW read issued in Execute, data back in LoadWait
  assign dataRead       = inExecute && decoded.memRead;
  assign dataWrite      = inExecute && decoded.memWrite;
  assign dataAddr       = result.dataAddr;
  assign dataWriteValue = storeData;

  assign regWriteEnable = retire && decoded.regWrite;
  assign regWriteAddr   = decoded.rd;
  assign regWriteData   = decoded.memRead ? loadData : result.aluResult;

  always_comb begin
    nextState = state;
    case (state)
      Idle:     if (run) nextState = Fetch;
      Fetch:    nextState = Execute;
      Execute,
      LoadWait: begin
        if (retire) begin
          if (decoded.stop) nextState = Halted;
          else if (run)     nextState = Fetch;
          else              nextState = Idle;
        end else begin
          nextState = LoadWait;
        end
      end
      default:  nextState = Halted; // Only reset leaves
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      state <= Idle;
      pc    <= '0;
    end else begin
      state <= nextState;
      if (retire) pc <= result.nextPc;
    end
  end

  assign trace.pc        = pc;
  assign trace.regWrite  = decoded.regWrite;
  assign trace.rd        = decoded.rd;
  assign trace.writeData = regWriteData;
  assign trace.memWrite  = decoded.memWrite;
  assign trace.memAddr   = result.dataAddr;
  assign trace.storeData = storeData;

  retireSingle: assert property (@(posedge clk) disable iff (reset)
    retire |=> !retire) else $error("Back-to-back retire");

  haltSticky: assert property (@(posedge clk) disable iff (reset)
    halted |=> (halted && !fetchEnable)) else $error("Fetch or exit after halt");

endmodule

`default_nettype wire

// ==== hdl/processor.sv ====
// Processor top level connecting memories, register file, decoder, ALU and sequencer
`default_nettype none
`include "cpuParams.svh"

module processor import cpuPkg::*; (
  input  logic         clk,
  input  logic         reset,
  input  logic         run,
  input  progWrite_t   progWrite,
  output logic         retire,
  output retireTrace_t trace,
  output logic         halted
);

  logic fetchEnable;
  logic [`CPU_IMEM_AW-1:0] pc;
  instr_t instruction;
  decodedInstr_t decoded;
  execResult_t result;
  word_t readDataA, readDataB, loadData, dataWriteValue, regWriteData;
  logic dataRead, dataWrite, regWriteEnable;
  logic [`CPU_DMEM_AW-1:0] dataAddr;
  logic [`CPU_REG_AW-1:0] regWriteAddr;

  syncRam #(.payload_t(instr_t), .addrWidth(`CPU_IMEM_AW)) instMem (
    .clk(clk), .writeEnable(progWrite.strobe), .writeAddr(progWrite.addr),
    .writeData(progWrite.instr), .readEnable(fetchEnable), .readAddr(pc),
    .readData(instruction));

  syncRam #(.payload_t(word_t), .addrWidth(`CPU_DMEM_AW)) dataMem (
    .clk(clk), .writeEnable(dataWrite), .writeAddr(dataAddr),
    .writeData(dataWriteValue), .readEnable(dataRead), .readAddr(dataAddr),
    .readData(loadData));

  instructionDecode decodeInst (.instruction(instruction), .decoded(decoded));

  // Port B index already steered to rd for I-type in the decoder
  registerFile regFile (
    .clk(clk), .reset(reset), .readAddrA(decoded.rs1), .readAddrB(decoded.rs2),
    .writeEnable(regWriteEnable), .writeAddr(regWriteAddr), .writeData(regWriteData),
    .readDataA(readDataA), .readDataB(readDataB));

  executeUnit execInst (
    .decoded(decoded), .pc(pc), .operandA(readDataA), .operandB(readDataB),
    .result(result));

  controlSequencer seqInst (
    .clk(clk), .reset(reset), .run(run), .decoded(decoded), .result(result),
    .storeData(readDataB), .loadData(loadData), .fetchEnable(fetchEnable), .pc(pc),
    .dataRead(dataRead), .dataWrite(dataWrite), .dataAddr(dataAddr),
    .dataWriteValue(dataWriteValue), .regWriteEnable(regWriteEnable),
    .regWriteAddr(regWriteAddr), .regWriteData(regWriteData), .retire(retire),
    .trace(trace), .halted(halted));

endmodule

`default_nettype wire

// ==== sim/processorTb.sv ====
// Processor testbench with program loader, LFSR, reference model and assertion checks
`default_nettype none
`include "cpuParams.svh"

module processorTb import cpuPkg::*; ();

  localparam int WaitLimit = 40;

  logic clk;
  logic reset;
  logic run;
  progWrite_t progWrite;
  logic retire;
  retireTrace_t trace;
  logic halted;

  // Reference model state
  instr_t prog [2**`CPU_IMEM_AW];
  word_t mRegs [2**`CPU_REG_AW];
  word_t mMem [2**`CPU_DMEM_AW];
  logic [`CPU_IMEM_AW-1:0] mPc;

  // Expected trace for the instruction at mPc
  logic expRegWrite, expMemWrite, expLoad, expStop;
  logic [`CPU_REG_AW-1:0] expRd;
  word_t expData, expStore;
  logic [`CPU_DMEM_AW-1:0] expAddr;
  logic [`CPU_IMEM_AW-1:0] expNextPc;

  logic [31:0] lfsr = 32'he580a89a;
  logic [`CPU_IMEM_AW-1:0] loadAddr;
  logic [2:0] gapCount; // Cycles since the last retire
  logic gapValid;
  logic haltSeen;
  logic [`CPU_IMEM_AW-1:0] lastRetiredPc;
  string testName;
  int errorCount, testsRun, testsFailed, errorsAtStart;

  processor processor_inst (.clk(clk), .reset(reset), .run(run), .progWrite(progWrite),
    .retire(retire), .trace(trace), .halted(halted));

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  always_comb begin
    instr_t ins;
    word_t a, b, d, immS;
    ins = prog[mPc];
    a = mRegs[ins[9:5]];
    b = mRegs[ins[19:15]];
    d = mRegs[ins[14:10]];
    immS = {{18{ins[28]}}, ins[28:15]};
    expRd = ins[14:10];
    expStop = ins[31];
    expRegWrite = 1'b0;
    expMemWrite = 1'b0;
    expLoad = 1'b0;
    expData = '0;
    expStore = d;
    expAddr = `CPU_DMEM_AW'(a + immS);
    expNextPc = mPc + `CPU_IMEM_AW'(1);
    case (ins[30:29])
      2'd0: begin // R group
        expRegWrite = ins[4:0] <= 5'd3;
        case (ins[4:0])
          5'd0: expData = a & b;
          5'd1: expData = a + b;
          5'd2: expData = a - b;
          5'd3: expData = word_t'(a < b);
          default: expData = '0;
        endcase
      end
      2'd3: begin // Shifts
        expRegWrite = ins[4:0] <= 5'd3;
        case (ins[4:0])
          5'd0: expData = a << ins[24:20];
          5'd1: expData = a >> ins[24:20];
          5'd2: expData = a << b[4:0];
          5'd3: expData = a >> b[4:0];
          default: expData = '0;
        endcase
      end
      2'd2: begin
        expRegWrite = ins[4:0] <= 5'd2;
        case (ins[4:0])
          5'd0: expData = a & {18'b0, ins[28:15]};
          5'd1: expData = a + immS;
          5'd2: begin
            expLoad = 1'b1;
            expData = mMem[expAddr];
          end
          5'd3: expMemWrite = 1'b1;
          5'd4: if (a == d) expNextPc = mPc + `CPU_IMEM_AW'(1) + immS[`CPU_IMEM_AW-1:0];
          default: expData = '0;
        endcase
      end
      default: if (ins[4:0] == 5'd0) expNextPc = mPc + `CPU_IMEM_AW'(1) + ins[12:5];
    endcase
  end

  always @(posedge clk or posedge reset) begin
    if (reset) begin
      for (int i = 0; i < 2**`CPU_REG_AW; i++) begin
        mRegs[i] <= '0;
      end
      mPc <= '0;
      gapCount <= '0;
      gapValid <= 1'b0;
      haltSeen <= 1'b0;
      lastRetiredPc <= '0;
    end else begin
      if (halted) haltSeen <= 1'b1;
      if (retire) begin
        if (expRegWrite && expRd != '0) mRegs[expRd] <= expData;
        if (expMemWrite) mMem[expAddr] <= expStore;
        mPc <= expNextPc;
        lastRetiredPc <= trace.pc;
        gapCount <= 3'd1;
        gapValid <= run; // Next fetch follows at once only if run held
      end else if (gapCount != 3'd7) begin
        gapCount <= gapCount + 3'd1;
      end
    end
  end

  task automatic reportValue(string field, word_t expected, word_t actual);
    $display("[FAIL] %s: %s expected %h actual %h", testName, field, expected, actual);
    errorCount++;
  endtask

  task automatic reportEvent(string what);
    $display("Error in %s: %s", testName, what);
    errorCount++;
  endtask

  pcCheck: assert property (@(posedge clk) disable iff (reset) retire |-> trace.pc == mPc)
    else reportValue("retired pc", word_t'($sampled(mPc)), word_t'($sampled(trace.pc)));
  regWriteCheck: assert property (@(posedge clk) disable iff (reset)
    retire |-> trace.regWrite == expRegWrite)
    else reportValue("regWrite", word_t'($sampled(expRegWrite)),
      word_t'($sampled(trace.regWrite)));
  rdCheck: assert property (@(posedge clk) disable iff (reset)
    retire && expRegWrite |-> trace.rd == expRd)
    else reportValue("rd", word_t'($sampled(expRd)), word_t'($sampled(trace.rd)));
  dataCheck: assert property (@(posedge clk) disable iff (reset)
    retire && expRegWrite |-> trace.writeData == expData)
    else reportValue("write data", $sampled(expData), $sampled(trace.writeData));
  memWriteCheck: assert property (@(posedge clk) disable iff (reset)
    retire |-> trace.memWrite == expMemWrite)
    else reportValue("memWrite", word_t'($sampled(expMemWrite)),
      word_t'($sampled(trace.memWrite)));
  addrCheck: assert property (@(posedge clk) disable iff (reset)
    retire && expMemWrite |-> trace.memAddr == expAddr)
    else reportValue("mem address", word_t'($sampled(expAddr)),
      word_t'($sampled(trace.memAddr)));
  storeCheck: assert property (@(posedge clk) disable iff (reset)
    retire && expMemWrite |-> trace.storeData == expStore)
    else reportValue("store data", $sampled(expStore), $sampled(trace.storeData));
  gapCheck: assert property (@(posedge clk) disable iff (reset)
    retire && gapValid |-> gapCount == (expLoad ? 3'd3 : 3'd2))
    else reportValue("retire spacing", word_t'($sampled(expLoad) ? 3 : 2),
      word_t'($sampled(gapCount)));
  haltRise: assert property (@(posedge clk) disable iff (reset) retire && expStop |=> halted)
    else reportEvent("halted did not rise after the stop instruction retired");
  haltQuiet: assert property (@(posedge clk) disable iff (reset)
    haltSeen |-> halted && !retire)
    else reportEvent("the core left the halted state or retired after halting");

  // Fibonacci LFSR, taps 32 22 2 1
  function automatic logic [31:0] randomBits(int count);
    logic [31:0] bits;
    logic feedback;
    bits = '0;
    for (int i = 0; i < count; i++) begin
      feedback = lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0];
      lfsr = {lfsr[30:0], feedback};
      bits = {bits[30:0], feedback};
    end
    return bits;
  endfunction

  function automatic instr_t encReg(instrType_e typ, opcode_e op, logic [4:0] rd,
                                    logic [4:0] rs1, logic [4:0] rs2, logic [4:0] sh);
    return {1'b0, typ, 4'b0, sh, rs2, rd, rs1, op};
  endfunction

  function automatic instr_t encImm(opcode_e op, logic [4:0] rd, logic [4:0] rs1,
                                    logic [13:0] imm);
    return {1'b0, TypeI, imm, rd, rs1, op};
  endfunction

  function automatic instr_t encJump(logic [23:0] offset);
    return {1'b0, TypeJ, offset, OpAnd};
  endfunction

  task automatic noteTimeout(string what);
    $display("Timeout in %s while waiting for %s", testName, what);
    errorCount++;
  endtask

  task automatic loadWord(instr_t word);
    prog[loadAddr] = word;
    progWrite.strobe <= 1'b1;
    progWrite.addr <= loadAddr;
    progWrite.instr <= word;
    loadAddr = loadAddr + `CPU_IMEM_AW'(1);
    @(posedge clk);
  endtask

  // Run is dropped once the second-to-last retire is seen
  task automatic runSegment(int count);
    int seen;
    int cycles;
    seen = 0;
    cycles = 0;
    progWrite.strobe <= 1'b0;
    run <= 1'b1;
    while (seen < count && cycles < WaitLimit * count) begin
      @(posedge clk);
      cycles++;
      if (retire) seen++;
      if (seen >= count - 1) run <= 1'b0;
    end
    if (seen < count) noteTimeout("retire");
  endtask

  task automatic startTest(string name);
    testName = name;
    errorsAtStart = errorCount;
    testsRun++;
  endtask

  task automatic finishTest();
    if (errorCount == errorsAtStart) begin
      $display("ok   %s", testName);
    end else begin
      $display("bad  %s (%0d errors)", testName, errorCount - errorsAtStart);
      testsFailed++;
    end
  endtask

  initial begin
    logic [13:0] offset;
    logic [`CPU_IMEM_AW-1:0] base;
    int cycles;
    reset = 1'b1;
    run = 1'b0;
    progWrite = '0;
    loadAddr = '0;
    errorCount = 0;
    testsRun = 0;
    testsFailed = 0;
    repeat (4) @(posedge clk);
    reset <= 1'b0;

    startTest("reset and idle");
    for (int i = 0; i < 12; i++) begin
      @(posedge clk);
      assert (!retire && !halted)
        else reportEvent("retire or halted went high while run was low");
    end
    loadWord(encImm(OpAdd, 5'd1, 5'd0, 14'(randomBits(14))));
    runSegment(1); // pcCheck expects 0 here
    finishTest();

    startTest("arithmetic and logic");
    // Negative sources so that ANDI zero extension shows in the upper bits
    loadWord(encImm(OpAdd, 5'd1, 5'd0, 14'(randomBits(14)) | 14'h2000));
    loadWord(encImm(OpAdd, 5'd2, 5'd1, 14'(randomBits(14)) | 14'h2000));
    loadWord(encImm(OpAnd, 5'd3, 5'd2, 14'(randomBits(14)) | 14'h2000));
    loadWord(encReg(TypeR, OpAnd, 5'd4, 5'd1, 5'd2, 5'd0));
    loadWord(encReg(TypeR, OpAdd, 5'd5, 5'd1, 5'd2, 5'd0));
    loadWord(encReg(TypeR, OpSub, 5'd6, 5'd1, 5'd2, 5'd0));
    loadWord(encReg(TypeR, OpCmp, 5'd7, 5'd1, 5'd2, 5'd0));
    loadWord(encReg(TypeR, OpCmp, 5'd8, 5'd2, 5'd1, 5'd0));
    loadWord(encImm(OpAdd, 5'd0, 5'd1, 14'(randomBits(14)))); // r0 stays zero
    loadWord(encReg(TypeR, OpAdd, 5'd9, 5'd0, 5'd1, 5'd0));
    runSegment(10);
    finishTest();

    startTest("shifts");
    loadWord(encReg(TypeS, OpAnd, 5'd10, 5'd1, 5'd0, 5'(randomBits(5))));
    loadWord(encReg(TypeS, OpAdd, 5'd11, 5'd2, 5'd0, 5'(randomBits(5))));
    loadWord(encImm(OpAdd, 5'd12, 5'd0, 14'(randomBits(14))));
    loadWord(encReg(TypeS, OpSub, 5'd13, 5'd1, 5'd12, 5'd0));
    loadWord(encReg(TypeS, OpCmp, 5'd14, 5'd2, 5'd12, 5'd0));
    runSegment(5);
    finishTest();

    startTest("memory");
    offset = 14'(randomBits(6));
    loadWord(encImm(OpAdd, 5'd15, 5'd0, 14'd20));
    loadWord(encImm(OpCmp, 5'd5, 5'd15, offset)); // SW r5
    loadWord(encImm(OpSub, 5'd16, 5'd15, offset)); // LW back
    loadWord(encReg(TypeR, OpAdd, 5'd17, 5'd16, 5'd0, 5'd0));
    loadWord(encImm(OpCmp, 5'd6, 5'd15, 14'h3fe2)); // 20 - 30 wraps to 246
    loadWord(encImm(OpSub, 5'd18, 5'd15, 14'h3fe2));
    loadWord(encImm(OpAdd, 5'd19, 5'd18, 14'd1));
    runSegment(7);
    finishTest();

    startTest("control flow");
    base = loadAddr;
    loadWord(encImm(OpAdd, 5'd1, 5'd0, 14'd7));
    loadWord(encImm(OpAdd, 5'd8, 5'd0, 14'd7));
    loadWord(encImm(OpBeq, 5'd8, 5'd1, 14'd1)); // Offset 1, taken
    loadWord(encImm(OpAdd, 5'd20, 5'd0, 14'd1));
    loadWord(encImm(OpBeq, 5'd0, 5'd1, 14'd1)); // Not taken
    loadWord(encJump(24'd2));
    loadWord(encImm(OpAdd, 5'd21, 5'd0, 14'd3));
    loadWord(encJump(24'd1)); // Leaves the loop
    loadWord(encJump(24'hfffffd)); // Back to base+6
    runSegment(8);
    @(posedge clk);
    assert (lastRetiredPc == base + `CPU_IMEM_AW'(7))
      else reportValue("last retired pc", word_t'(base + `CPU_IMEM_AW'(7)),
        word_t'(lastRetiredPc));
    finishTest();

    startTest("stop");
    loadWord(encImm(OpAdd, 5'd22, 5'd0, 14'd5) | 32'h8000_0000);
    runSegment(1);
    cycles = 0;
    while (!halted && cycles < WaitLimit) begin
      @(posedge clk);
      cycles++;
    end
    if (!halted) noteTimeout("halted");
    run <= 1'b1;
    repeat (30) @(posedge clk); // haltQuiet watches this window
    run <= 1'b0;
    finishTest();

    $display("Summary: %0d tests, %0d failed, %0d check errors",
      testsRun, testsFailed, errorCount);
    if (testsFailed == 0 && errorCount == 0) begin
      $display("TESTS PASSED");
    end else begin
      $display("TESTS FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== project.f ====
+incdir+hdl
hdl/cpuPkg.sv
hdl/syncRam.sv
hdl/registerFile.sv
hdl/instructionDecode.sv
hdl/executeUnit.sv
hdl/controlSequencer.sv
hdl/processor.sv
sim/processorTb.sv

// ==== Makefile ====
# Verilator build and run for the multi-cycle processor

VERILATOR ?= verilator
TOP       ?= processorTb
FILELIST  ?= project.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --assert -j 0

SOURCES := $(wildcard hdl/*.sv hdl/*.svh sim/*.sv)
BIN     := $(BUILD_DIR)/V$(TOP)

.PHONY: all build run check clean

all: check

build: $(BIN)

$(BIN): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(BIN)
	./$(BIN) 2>&1 | tee $(LOG)
	@! grep -q "TESTS FAILED" $(LOG)

check: run
	@grep -q "TESTS PASSED" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)
